//--- logic/link_phy_pkg.sv
package link_phy_pkg;

  ////////////////////
  // Lane word layout

  // Raw PHY word per lane per clock
  localparam int LANE_WIDTH = 40;

  // Lower bits carry flit payload
  localparam int LANE_PAYLOAD = 38;

  // Sync bits at the top of every lane word
  localparam int LANE_STB_BIT = 38;
  localparam int LANE_MRK_BIT = 39;

  typedef logic [LANE_WIDTH-1:0] lane_word_t;

  ////////////////////
  // Online delay

  // Cycles to hold off after an online request
  localparam int DELAY_CNT_W = 8;

  typedef logic [DELAY_CNT_W-1:0] delay_cnt_t;

endpackage

//--- logic/lpif_pkg.sv
package lpif_pkg;

  ////////////////////
  // User channel fields

  localparam int STATE_W  = 4;
  localparam int PROTID_W = 2;
  localparam int DATA_W   = 64;
  localparam int BSTART_W = 3;
  localparam int BVALID_W = 8;

  typedef logic [STATE_W-1:0]  state_t;
  typedef logic [PROTID_W-1:0] protid_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [BSTART_W-1:0] bstart_t;
  typedef logic [BVALID_W-1:0] bvalid_t;

  ////////////////////
  // Flit layout

  // State in the top bits, valid in bit 0
  localparam int FLIT_W = STATE_W + PROTID_W + DATA_W + BSTART_W + BVALID_W + 1;

  localparam int FLIT_VALID_BIT  = 0;
  localparam int FLIT_BVALID_LSB = FLIT_VALID_BIT + 1;
  localparam int FLIT_BSTART_LSB = FLIT_BVALID_LSB + BVALID_W;
  localparam int FLIT_DATA_LSB   = FLIT_BSTART_LSB + BSTART_W;
  localparam int FLIT_PROTID_LSB = FLIT_DATA_LSB + DATA_W;
  localparam int FLIT_STATE_LSB  = FLIT_PROTID_LSB + PROTID_W;

  typedef logic [FLIT_W-1:0] flit_t;

  // Flow control and status
  localparam int CREDIT_W = 8;
  localparam int DEBUG_W  = 32;

  typedef logic [CREDIT_W-1:0] credit_t;
  typedef logic [DEBUG_W-1:0]  debug_t;

  // Receive lane alignment
  typedef enum logic [1:0] {
    ALIGN_WAIT,
    ALIGN_LOCKED,
    ALIGN_ERROR
  } rx_align_e;

endpackage

//--- logic/lpif_flit_if.sv
`timescale 1ns/10ps

interface lpif_flit_if
  import lpif_pkg::*;
();

  // One flit per clock plus sideband
  flit_t flit;
  logic  flit_valid;

  // Single credit-return pulse riding along with the flit
  logic  credit;

  // Producer side is up and its content may be used
  logic  online;

  // Producer
  modport src (
    output flit,
    output flit_valid,
    output credit,
    output online
  );

  // Consumer
  modport dst (
    input  flit,
    input  flit_valid,
    input  credit,
    input  online
  );

endinterface

//--- logic/lpif_auto_sync.sv
`timescale 1ns/10ps

module lpif_auto_sync
  import link_phy_pkg::*;
#(
  parameter int STROBE_PERIOD = 4
) (
  input  logic       clk_wr,
  input  logic       reset,

  input  logic       tx_online,
  input  logic       rx_online,
  input  delay_cnt_t delay_xz_value,
  input  delay_cnt_t delay_x_value,

  output logic       tx_online_delay,
  output logic       rx_online_delay,
  output logic       tx_stb_userbit,
  output logic       tx_mrk_userbit
);

  localparam int STB_CNT_W = (STROBE_PERIOD > 1) ? $clog2(STROBE_PERIOD) : 1;
  localparam logic [STB_CNT_W-1:0] STB_LAST = STB_CNT_W'(STROBE_PERIOD - 1);

  // Index 0 is transmit, index 1 is receive
  logic       [1:0]         online_in;
  logic       [1:0]         online_out;
  delay_cnt_t               dly_val [2];
  delay_cnt_t               dly_cnt [2];
  logic       [STB_CNT_W-1:0] stb_cnt;

  ////////////////////
  // Online delay

  assign online_in  = {rx_online, tx_online};
  assign dly_val[0] = delay_xz_value;
  assign dly_val[1] = delay_x_value;

  // Reload while offline, run down to zero once online
  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      if (reset || !online_in[i]) begin
        dly_cnt[i] <= dly_val[i];
      end else if (dly_cnt[i] != '0) begin
        dly_cnt[i] <= dly_cnt[i] - 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      online_out[i] = online_in[i] && (dly_cnt[i] == '0);
    end
  end

  assign tx_online_delay = online_out[0];
  assign rx_online_delay = online_out[1];

  ////////////////////
  // Strobe and marker

  // Word counter restarts on every online transition
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      stb_cnt <= '0;
    end else if (stb_cnt == STB_LAST) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  // First online word always carries a strobe
  assign tx_stb_userbit = tx_online_delay && (stb_cnt == '0);

  // Persistent marker
  assign tx_mrk_userbit = tx_online_delay;

  ////////////////////
  // Checks

  // Word counter must be back at zero when transmit comes online
  a_stb_first: assert property (
    @(posedge clk_wr) disable iff (reset)
    $rose(tx_online_delay) |-> tx_stb_userbit
  ) else $error("First online word carries no strobe");

endmodule

//--- logic/lpif_user_if.sv
`timescale 1ns/10ps

module lpif_user_if
  import lpif_pkg::*;
(
  input  logic     clk_wr,
  input  logic     reset,

  input  credit_t  init_downstream_credit,

  // Downstream channel
  input  state_t   dstrm_state,
  input  protid_t  dstrm_protid,
  input  data_t    dstrm_data,
  input  bstart_t  dstrm_bstart,
  input  bvalid_t  dstrm_bvalid,
  input  logic     dstrm_valid,
  output logic     dstrm_credit_avail,

  // Upstream channel
  input  logic     ustrm_credit,
  output state_t   ustrm_state,
  output protid_t  ustrm_protid,
  output data_t    ustrm_data,
  output bstart_t  ustrm_bstart,
  output bvalid_t  ustrm_bvalid,
  output logic     ustrm_valid,

  output debug_t   tx_downstream_debug_status,
  output debug_t   rx_upstream_debug_status,
  input  logic     rx_align_error,

  lpif_flit_if.src tx_flit,
  lpif_flit_if.dst rx_flit
);

  credit_t            credit_cnt;
  logic               credit_loaded;
  logic               dstrm_accept;
  logic               credit_return;
  logic               ustrm_accept;
  logic [DEBUG_W-2:0] tx_beat_cnt;
  logic [DEBUG_W-2:0] rx_beat_cnt;

  assign dstrm_credit_avail = (credit_cnt != '0);
  assign dstrm_accept       = dstrm_valid && dstrm_credit_avail;
  assign credit_return      = rx_flit.credit && rx_flit.online;
  assign ustrm_accept       = rx_flit.flit_valid && rx_flit.online;

  ////////////////////
  // Downstream

  // Beats without credit go out with the valid bit low
  always_ff @(posedge clk_wr) begin
    tx_flit.flit <= {dstrm_state, dstrm_protid, dstrm_data,
                     dstrm_bstart, dstrm_bvalid, dstrm_accept};
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_flit.flit_valid <= 1'b0;
      tx_flit.credit     <= 1'b0;
    end else begin
      tx_flit.flit_valid <= dstrm_accept;
      tx_flit.credit     <= ustrm_credit;
    end
  end

  // Lanes carry user content only once credit is set up
  assign tx_flit.online = credit_loaded;

  // Load once after reset, then spend and return
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_loaded <= 1'b0;
      credit_cnt    <= '0;
    end else if (!credit_loaded) begin
      credit_loaded <= 1'b1;
      credit_cnt    <= init_downstream_credit;
    end else begin
      credit_cnt <= credit_cnt - credit_t'(dstrm_accept) + credit_t'(credit_return);
    end
  end

  ////////////////////
  // Upstream

  always_ff @(posedge clk_wr) begin
    ustrm_state  <= rx_flit.flit[FLIT_STATE_LSB +: STATE_W];
    ustrm_protid <= rx_flit.flit[FLIT_PROTID_LSB +: PROTID_W];
    ustrm_data   <= rx_flit.flit[FLIT_DATA_LSB +: DATA_W];
    ustrm_bstart <= rx_flit.flit[FLIT_BSTART_LSB +: BSTART_W];
    ustrm_bvalid <= rx_flit.flit[FLIT_BVALID_LSB +: BVALID_W];
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm_valid <= 1'b0;
    end else begin
      ustrm_valid <= ustrm_accept;
    end
  end

  // Beat counters for debug status
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_beat_cnt <= '0;
      rx_beat_cnt <= '0;
    end else begin
      if (dstrm_accept) tx_beat_cnt <= tx_beat_cnt + 1'b1;
      if (ustrm_accept) rx_beat_cnt <= rx_beat_cnt + 1'b1;
    end
  end

  assign tx_downstream_debug_status = {1'b0, tx_beat_cnt};
  assign rx_upstream_debug_status   = {rx_align_error, rx_beat_cnt};

  // Sender must respect the credit it was granted
  a_dstrm_credit: assert property (
    @(posedge clk_wr) disable iff (reset)
    credit_loaded && dstrm_valid |-> dstrm_credit_avail
  ) else $error("Downstream beat sent without credit");

endmodule

//--- logic/lpif_lane_concat.sv
`timescale 1ns/10ps

module lpif_lane_concat
  import link_phy_pkg::*, lpif_pkg::*;
#(
  parameter int NUM_LANES     = 3,
  parameter int STROBE_PERIOD = 4
) (
  input  logic                         clk_wr,
  input  logic                         reset,
  input  logic                         tx_online,
  input  logic                         rx_online,
  input  logic                         tx_stb_userbit,
  input  logic                         tx_mrk_userbit,

  output lane_word_t [NUM_LANES-1:0]   tx_phy,
  input  lane_word_t [NUM_LANES-1:0]   rx_phy,
  output logic                         rx_align_error,

  lpif_flit_if.dst                     tx_flit,
  lpif_flit_if.src                     rx_flit
);

  localparam int PAY_TOTAL  = NUM_LANES * LANE_PAYLOAD;
  localparam int CREDIT_BIT = FLIT_W;
  localparam int STB_CNT_W  = (STROBE_PERIOD > 1) ? $clog2(STROBE_PERIOD) : 1;
  localparam logic [STB_CNT_W-1:0] STB_LAST = STB_CNT_W'(STROBE_PERIOD - 1);

  logic [PAY_TOTAL-1:0] tx_payload;
  logic [PAY_TOTAL-1:0] rx_payload;
  logic [NUM_LANES-1:0] rx_stb;
  logic [NUM_LANES-1:0] rx_mrk;
  logic                 rx_stb_all;
  logic                 rx_stb_any;
  logic                 rx_mrk_all;
  logic                 rx_stb_due;
  rx_align_e            align_state;
  logic [STB_CNT_W-1:0] rx_stb_cnt;

  ////////////////////
  // Transmit

  // Idle words carry zero payload
  always_comb begin
    tx_payload = '0;
    if (tx_flit.online) begin
      if (tx_flit.flit_valid) tx_payload[FLIT_W-1:0] = tx_flit.flit;
      tx_payload[CREDIT_BIT] = tx_flit.credit;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_phy <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        tx_phy[i][LANE_PAYLOAD-1:0] <= tx_payload[i*LANE_PAYLOAD +: LANE_PAYLOAD];
        tx_phy[i][LANE_STB_BIT]     <= tx_stb_userbit;
        tx_phy[i][LANE_MRK_BIT]     <= tx_mrk_userbit;
      end
    end
  end

  ////////////////////
  // Receive

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rx_payload[i*LANE_PAYLOAD +: LANE_PAYLOAD] = rx_phy[i][LANE_PAYLOAD-1:0];
      rx_stb[i] = rx_phy[i][LANE_STB_BIT];
      rx_mrk[i] = rx_phy[i][LANE_MRK_BIT];
    end
  end

  assign rx_stb_all = &rx_stb;
  assign rx_stb_any = |rx_stb;
  assign rx_mrk_all = &rx_mrk;
  assign rx_stb_due = (rx_stb_cnt == '0);

  always_ff @(posedge clk_wr) begin
    rx_flit.flit <= rx_payload[FLIT_W-1:0];
  end

  // Words without a marker are not live
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_flit.flit_valid <= 1'b0;
      rx_flit.credit     <= 1'b0;
    end else begin
      rx_flit.flit_valid <= rx_mrk_all && rx_payload[FLIT_VALID_BIT];
      rx_flit.credit     <= rx_mrk_all && rx_payload[CREDIT_BIT];
    end
  end

  assign rx_flit.online = rx_online;

  // Alignment FSM, lock on first strobe then expect it every period
  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      align_state <= ALIGN_WAIT;
      rx_stb_cnt  <= '0;
    end else begin
      case (align_state)
        ALIGN_WAIT: begin
          if (rx_stb_any) begin
            align_state <= (rx_stb_all && rx_mrk_all) ? ALIGN_LOCKED : ALIGN_ERROR;
            rx_stb_cnt  <= (STB_LAST == '0) ? '0 : STB_CNT_W'(1);
          end
        end
        ALIGN_LOCKED: begin
          // Lane skew, missing marker or misplaced strobe
          if (!rx_mrk_all || (rx_stb_any != rx_stb_all) || (rx_stb_all != rx_stb_due)) begin
            align_state <= ALIGN_ERROR;
          end
          rx_stb_cnt <= (rx_stb_cnt == STB_LAST) ? '0 : rx_stb_cnt + 1'b1;
        end
        default: align_state <= ALIGN_ERROR;
      endcase
    end
  end

  assign rx_align_error = (align_state == ALIGN_ERROR);

  // Lanes must hold the whole flit plus the credit bit
  a_lane_cover: assert property (
    @(posedge clk_wr) PAY_TOTAL >= CREDIT_BIT + 1
  ) else $error("NUM_LANES too small for flit and credit bit");

endmodule

//--- logic/lpif_link_master_top.sv
`timescale 1ns/10ps

module lpif_link_master_top
  import link_phy_pkg::*, lpif_pkg::*;
#(
  parameter int NUM_LANES     = 3,
  parameter int STROBE_PERIOD = 4
) (
  input  logic                            clk_wr,
  input  logic                            reset,

  // Control
  input  logic                            tx_online,
  input  logic                            rx_online,
  input  credit_t                         init_downstream_credit,
  input  delay_cnt_t                      delay_x_value,
  input  delay_cnt_t                      delay_xz_value,

  // PHY lanes, lane 0 in the low bits
  output logic [NUM_LANES*LANE_WIDTH-1:0] tx_phy,
  input  logic [NUM_LANES*LANE_WIDTH-1:0] rx_phy,

  // Downstream channel
  input  state_t                          dstrm_state,
  input  protid_t                         dstrm_protid,
  input  data_t                           dstrm_data,
  input  bstart_t                         dstrm_bstart,
  input  bvalid_t                         dstrm_bvalid,
  input  logic                            dstrm_valid,
  output logic                            dstrm_credit_avail,

  // Upstream channel
  input  logic                            ustrm_credit,
  output state_t                          ustrm_state,
  output protid_t                         ustrm_protid,
  output data_t                           ustrm_data,
  output bstart_t                         ustrm_bstart,
  output bvalid_t                         ustrm_bvalid,
  output logic                            ustrm_valid,

  // Debug
  output debug_t                          tx_downstream_debug_status,
  output debug_t                          rx_upstream_debug_status
);

  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_stb_userbit;
  logic tx_mrk_userbit;
  logic rx_align_error;

  lpif_flit_if tx_flit ();
  lpif_flit_if rx_flit ();

  ////////////////////
  // Online delay and sync bits

  lpif_auto_sync #(
    .STROBE_PERIOD (STROBE_PERIOD)
  ) u_auto_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_xz_value  (delay_xz_value),
    .delay_x_value   (delay_x_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit)
  );

  ////////////////////
  // User side

  lpif_user_if u_user_if (
    .clk_wr                     (clk_wr),
    .reset                      (reset),
    .init_downstream_credit     (init_downstream_credit),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_bstart               (dstrm_bstart),
    .dstrm_bvalid               (dstrm_bvalid),
    .dstrm_valid                (dstrm_valid),
    .dstrm_credit_avail         (dstrm_credit_avail),
    .ustrm_credit               (ustrm_credit),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_bstart               (ustrm_bstart),
    .ustrm_bvalid               (ustrm_bvalid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status),
    .rx_align_error             (rx_align_error),
    .tx_flit                    (tx_flit.src),
    .rx_flit                    (rx_flit.dst)
  );

  ////////////////////
  // PHY side

  lpif_lane_concat #(
    .NUM_LANES     (NUM_LANES),
    .STROBE_PERIOD (STROBE_PERIOD)
  ) u_lane_concat (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_online      (tx_online_delay),
    .rx_online      (rx_online_delay),
    .tx_stb_userbit (tx_stb_userbit),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_phy         (tx_phy),
    .rx_phy         (rx_phy),
    .rx_align_error (rx_align_error),
    .tx_flit        (tx_flit.dst),
    .rx_flit        (rx_flit.src)
  );

endmodule

//--- tests/lpif_link_tb_ref.svh
`ifndef LPIF_LINK_TB_REF_SVH
`define LPIF_LINK_TB_REF_SVH

////////////////////
// Flit packing

// State in the top bits, valid in bit 0
function automatic flit_t pack_flit(input state_t state, input protid_t protid,
                                    input data_t data, input bstart_t bstart,
                                    input bvalid_t bvalid, input logic valid);
  return {state, protid, data, bstart, bvalid, valid};
endfunction

////////////////////
// Lane mapping

// Flit bit k lands in lane k/38 at payload bit k%38, credit right after the flit
function automatic phy_bus_t expected_lanes(input flit_t flit, input logic flit_valid,
                                            input logic credit, input logic stb,
                                            input logic mrk);
  phy_bus_t words;
  int       k;
  words = '0;
  for (int lane = 0; lane < NUM_LANES; lane++) begin
    for (int b = 0; b < LANE_PAYLOAD; b++) begin
      k = lane * LANE_PAYLOAD + b;
      if (k < FLIT_W) begin
        words[lane * LANE_WIDTH + b] = flit_valid & flit[k];
      end else if (k == FLIT_W) begin
        words[lane * LANE_WIDTH + b] = credit;
      end
    end
    words[lane * LANE_WIDTH + LANE_STB_BIT] = stb;
    words[lane * LANE_WIDTH + LANE_MRK_BIT] = mrk;
  end
  return words;
endfunction

////////////////////
// Compare

task automatic check_value(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
  if (got !== exp) begin
    error_count++;
    $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
  end
endtask

`endif

//--- tests/lpif_link_tb.sv
`timescale 1ns/10ps

module lpif_link_tb
  import link_phy_pkg::*, lpif_pkg::*;
();

  localparam int NUM_LANES     = 3;
  localparam int STROBE_PERIOD = 4;
  localparam int PHY_W         = NUM_LANES * LANE_WIDTH;
  localparam int RESET_CYCLES  = 16;
  localparam int RANDOM_BEATS  = 100;
  localparam int INIT_CREDIT   = 5;
  localparam int XZ_DELAY      = 6;
  localparam int X_DELAY       = 10;
  // Tests need roughly 400 cycles, the rest is margin
  localparam int MAX_CYCLES    = 2000;

  typedef logic [PHY_W-1:0] phy_bus_t;

  logic       clk;
  logic       reset;
  logic       tx_online;
  logic       rx_online;
  credit_t    init_downstream_credit;
  delay_cnt_t delay_x_value;
  delay_cnt_t delay_xz_value;
  phy_bus_t   tx_phy;
  phy_bus_t   rx_phy;
  state_t     dstrm_state;
  protid_t    dstrm_protid;
  data_t      dstrm_data;
  bstart_t    dstrm_bstart;
  bvalid_t    dstrm_bvalid;
  logic       dstrm_valid;
  logic       dstrm_credit_avail;
  logic       ustrm_credit;
  state_t     ustrm_state;
  protid_t    ustrm_protid;
  data_t      ustrm_data;
  bstart_t    ustrm_bstart;
  bvalid_t    ustrm_bvalid;
  logic       ustrm_valid;
  debug_t     tx_downstream_debug_status;
  debug_t     rx_upstream_debug_status;

  int     error_count = 0;
  int     cycle       = 0;
  integer seed        = 70;
  int     tx_total    = 0;
  int     rx_total    = 0;
  logic   checking    = 1'b0;
  flit_t  exp_flits[$];
  int     exp_cycles[$];

  // Transmit word model
  phy_bus_t exp_phy      = '0;
  flit_t    stage_flit   = '0;
  logic     stage_valid  = 1'b0;
  logic     stage_credit = 1'b0;
  int       tx_seen      = 0;
  int       word_idx     = 0;

  `include "lpif_link_tb_ref.svh"

  // PHY loopback
  assign rx_phy = tx_phy;

  lpif_link_master_top #(
    .NUM_LANES     (NUM_LANES),
    .STROBE_PERIOD (STROBE_PERIOD)
  ) UUT (
    .clk_wr                     (clk),
    .reset                      (reset),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .init_downstream_credit     (init_downstream_credit),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .tx_phy                     (tx_phy),
    .rx_phy                     (rx_phy),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_bstart               (dstrm_bstart),
    .dstrm_bvalid               (dstrm_bvalid),
    .dstrm_valid                (dstrm_valid),
    .dstrm_credit_avail         (dstrm_credit_avail),
    .ustrm_credit               (ustrm_credit),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_bstart               (ustrm_bstart),
    .ustrm_bvalid               (ustrm_bvalid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles with %0d errors", cycle, error_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic send_random_beat(output flit_t sent);
    logic [31:0] r;
    r = $random(seed);
    dstrm_state  = r[3:0];
    dstrm_protid = r[5:4];
    dstrm_bstart = r[8:6];
    dstrm_bvalid = r[16:9];
    dstrm_data   = {$random(seed), $random(seed)};
    dstrm_valid  = 1'b1;
    tx_total++;
    sent = pack_flit(dstrm_state, dstrm_protid, dstrm_data, dstrm_bstart, dstrm_bvalid, 1'b1);
  endtask

  task automatic expect_upstream(input flit_t f);
    exp_flits.push_back(f);
    exp_cycles.push_back(cycle);
    rx_total++;
  endtask

  task automatic check_upstream();
    flit_t got;
    got = pack_flit(ustrm_state, ustrm_protid, ustrm_data, ustrm_bstart, ustrm_bvalid, 1'b1);
    if (exp_flits.size() == 0) begin
      error_count++;
      $display("Error at %0t ns: upstream beat arrived with none outstanding", $time);
    end else begin
      check_value("ustrm flit", got, exp_flits.pop_front());
      check_value("ustrm arrival cycle", cycle, exp_cycles.pop_front() + 4);
    end
  endtask

  ////////////////////
  // Comparison

  // Lane word expected two edges after the inputs, once the online delay has run out
  always @(negedge clk) begin
    if (checking) begin
      check_value("tx_phy", tx_phy, exp_phy);
      if (ustrm_valid) check_upstream();
    end
    if (tx_online && tx_seen >= delay_xz_value) begin
      exp_phy = expected_lanes(stage_flit, stage_valid, stage_credit,
                               (word_idx % STROBE_PERIOD) == 0, 1'b1);
      word_idx++;
    end else begin
      exp_phy  = '0;
      word_idx = 0;
    end
    tx_seen      = tx_online ? tx_seen + 1 : 0;
    stage_flit   = pack_flit(dstrm_state, dstrm_protid, dstrm_data,
                             dstrm_bstart, dstrm_bvalid, 1'b1);
    stage_valid  = dstrm_valid;
    stage_credit = ustrm_credit;
  end

  ////////////////////
  // Stimulus

  initial begin : stimulus
    int          sent;
    int          lat;
    int          credit_model;
    logic [2:0]  credit_pipe;
    logic        do_send;
    flit_t       f;
    logic [31:0] r;
    reset = 1'b1;
    tx_online = 1'b0;
    rx_online = 1'b0;
    init_downstream_credit = credit_t'(INIT_CREDIT);
    delay_xz_value = delay_cnt_t'(XZ_DELAY);
    delay_x_value = delay_cnt_t'(X_DELAY);
    dstrm_state = '0;
    dstrm_protid = '0;
    dstrm_data = '0;
    dstrm_bstart = '0;
    dstrm_bvalid = '0;
    dstrm_valid = 1'b0;
    ustrm_credit = 1'b0;

    repeat (RESET_CYCLES - 1) next_cycle();
    @(negedge clk);
    check_value("tx_phy in reset", tx_phy, 0);
    check_value("ustrm_valid in reset", ustrm_valid, 0);
    check_value("credit avail in reset", dstrm_credit_avail, 0);
    check_value("tx debug in reset", tx_downstream_debug_status, 0);
    check_value("rx debug in reset", rx_upstream_debug_status, 0);
    next_cycle();
    reset = 1'b0;
    checking = 1'b1;
    repeat (4) next_cycle();

    // Count edges until the first lane word, edge 1 samples tx_online
    tx_online = 1'b1;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (tx_phy === '0);
    check_value("tx online delay", lat - 1, delay_xz_value);
    repeat (3 * STROBE_PERIOD) next_cycle();

    // Spend the initial credit while receive waits out its delay
    rx_online = 1'b1;
    sent = 0;
    while (dstrm_credit_avail && sent < 2 * INIT_CREDIT) begin
      check_value("ustrm_valid during rx delay", ustrm_valid, 0);
      send_random_beat(f);
      sent++;
      next_cycle();
    end
    dstrm_valid = 1'b0;
    check_value("beats on initial credit", sent, INIT_CREDIT);
    repeat (X_DELAY - INIT_CREDIT) begin
      check_value("credit avail when spent", dstrm_credit_avail, 0);
      check_value("ustrm_valid during rx delay", ustrm_valid, 0);
      next_cycle();
    end
    repeat (4) next_cycle();

    // A returned credit takes the same four-cycle loop as a beat
    repeat (3) begin
      ustrm_credit = 1'b1;
      next_cycle();
      ustrm_credit = 1'b0;
      lat = 1;
      while (!dstrm_credit_avail && lat < 20) begin
        next_cycle();
        lat++;
      end
      check_value("credit return latency", lat, 4);
      if (dstrm_credit_avail) begin
        send_random_beat(f);
        expect_upstream(f);
        next_cycle();
        dstrm_valid = 1'b0;
        check_value("credit avail after spend", dstrm_credit_avail, 0);
      end
    end

    // Random traffic with random credit return
    // A returned credit counts four cycles after its pulse, a beat spends one next cycle
    sent = 0;
    credit_model = 0;
    credit_pipe = '0;
    while (sent < RANDOM_BEATS) begin
      check_value("credit avail", dstrm_credit_avail, credit_model != 0);
      r = $random(seed);
      ustrm_credit = r[0];
      dstrm_valid = 1'b0;
      do_send = dstrm_credit_avail && (r[2:1] != 2'b00);
      if (do_send) begin
        send_random_beat(f);
        expect_upstream(f);
        sent++;
      end
      credit_model = credit_model - int'(do_send) + int'(credit_pipe[2]);
      credit_pipe = {credit_pipe[1:0], ustrm_credit};
      next_cycle();
    end
    dstrm_valid = 1'b0;
    ustrm_credit = 1'b0;
    while (exp_flits.size() != 0) next_cycle();
    repeat (2) next_cycle();

    check_value("tx debug status", tx_downstream_debug_status, tx_total);
    check_value("rx debug status", rx_upstream_debug_status, rx_total);

    $display("Checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/link_phy_pkg.sv
logic/lpif_pkg.sv
logic/lpif_flit_if.sv
logic/lpif_auto_sync.sv
logic/lpif_user_if.sv
logic/lpif_lane_concat.sv
logic/lpif_link_master_top.sv
tests/lpif_link_tb.sv
+incdir+tests

//--- Makefile
# Verilator build and run for the LPIF link master testbench

VERILATOR ?= verilator
TOP       ?= lpif_link_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
